/* logic/bp_pkg.sv */
package bp_pkg;

    // index and history width
    localparam int h_width = 8;
    // pc word address, byte offset stripped
    localparam int addr_width = 30;
    // number of table entries
    localparam int pht_depth = 1 << h_width;

    typedef logic [addr_width-1:0] pc_t;
    typedef logic [h_width-1:0]    bh_index_t;

    // 2-bit saturating counter
    // 0 strong nt, 1 weak nt, 2 weak t, 3 strong t
    typedef logic [1:0] pht_cnt_t;

    localparam pht_cnt_t pht_init_val = 2'd1;
    localparam pht_cnt_t pht_cnt_max  = 2'd3;
    localparam pht_cnt_t pht_cnt_min  = 2'd0;

    // bit 2 set means always taken, bit 0 alone means direct
    typedef enum logic [2:0] {
        not_jump      = 3'd0,
        direct_jump   = 3'd1,
        ret           = 3'd4,
        indirect_jump = 3'd5,
        call          = 3'd6,
        jump          = 3'd7
    } br_kind_t;

    typedef enum logic [1:0] {
        init_idle,
        init_sweep,
        init_done
    } init_state_t;

    // returned by execute together with the real outcome
    typedef struct packed {
        pc_t       pc_ex;
        bh_index_t index_ex;
        br_kind_t  kind_ex;
        logic      taken_real;
        pht_cnt_t  pdch_ex;
    } ex_info_s;

    // one table write
    typedef struct packed {
        logic      wr_en;
        bh_index_t wr_index;
        pht_cnt_t  wr_cnt;
    } pht_wr_s;

    // fetch side result, echoed back later through ex_info
    typedef struct packed {
        logic      taken_pdc;
        pht_cnt_t  pdch;
        bh_index_t index;
    } pdc_info_s;

endpackage

/* logic/bh_hash.sv */
module bh_hash import bp_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    input  pc_t       pc_reg,
    input  logic      hist_shift,
    input  logic      hist_bit,
    output bh_index_t index
);

    // global history of committed direct jumps
    // newest outcome sits in bit 0
    bh_index_t ghist;

    // low pc bits of the fetch address
    bh_index_t pc_low;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ghist <= '0;
        end else if (hist_shift) begin
            // shift in the resolved outcome
            ghist <= {ghist[h_width-2:0], hist_bit};
        end
    end

    assign pc_low = pc_reg[h_width-1:0];

    // gshare style fold, pc xor history
    // history update is seen one cycle after the strobe
    assign index = pc_low ^ ghist;

endmodule

/* logic/bpht.sv */
module bpht import bp_pkg::*; (
    input  logic      clk,
    input  bh_index_t index,
    output pht_cnt_t  pdch,
    input  pht_wr_s   pht_wr,
    input  pht_wr_s   init_wr
);

    // pattern history table
    // 256 entries of 2-bit counters
    pht_cnt_t pht_mem [pht_depth];

    // write port after arbitration
    pht_wr_s wr_sel;

    // init sweep wins over execute updates
    // they never collide since updates wait for ready
    always_comb begin
        if (init_wr.wr_en) begin
            wr_sel = init_wr;
        end else begin
            wr_sel = pht_wr;
        end
    end

    // single write per clock
    always_ff @(posedge clk) begin
        if (wr_sel.wr_en) begin
            pht_mem[wr_sel.wr_index] <= wr_sel.wr_cnt;
        end
    end

    // async read for the fetch stage
    // no bypass from a write in the same cycle
    assign pdch = pht_mem[index];

endmodule

/* logic/pht_init_fsm.sv */
module pht_init_fsm import bp_pkg::*; (
    input  logic    clk,
    input  logic    arst_n,
    output pht_wr_s init_wr,
    output logic    ready
);

    init_state_t state;
    init_state_t state_nxt;

    // entry being written by the sweep
    bh_index_t sweep_idx;
    logic      sweep_last;

    assign sweep_last = (sweep_idx == bh_index_t'(pht_depth - 1));

    // next state
    always_comb begin
        state_nxt = state;
        case (state)
            init_idle: begin
                state_nxt = init_sweep;
            end
            init_sweep: begin
                if (sweep_last) begin
                    state_nxt = init_done;
                end
            end
            init_done: begin
                // stays here until reset
                state_nxt = init_done;
            end
            default: begin
                state_nxt = init_idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= init_idle;
            sweep_idx <= '0;
            ready     <= 1'b0;
        end else begin
            state <= state_nxt;
            // step through the table one entry per cycle
            if (state == init_sweep) begin
                sweep_idx <= sweep_idx + 1'b1;
            end
            // ready one cycle after entering init_done
            if (state == init_done) begin
                ready <= 1'b1;
            end
        end
    end

    // every entry starts weakly not taken
    assign init_wr.wr_en    = (state == init_sweep);
    assign init_wr.wr_index = sweep_idx;
    assign init_wr.wr_cnt   = pht_init_val;

endmodule

/* logic/aim_predictor0.sv */
module aim_predictor0 import bp_pkg::*; (
    input  logic      ready,
    input  logic      update_en,
    input  ex_info_s  ex_info,
    input  br_kind_t  kind_pdc,
    input  pht_cnt_t  pdch,
    input  bh_index_t index,
    output pdc_info_s pdc_out,
    output pht_wr_s   pht_wr,
    output logic      hist_shift,
    output logic      hist_bit
);

    // only direct jumps train the table
    logic try_to_pdc;
    // update accepted this cycle
    logic upd_take;
    // counter after one step toward the outcome
    pht_cnt_t cnt_new;

    // ret, indirect, call, jump always taken
    // direct jump follows counter msb, not_jump never taken
    assign pdc_out.taken_pdc = kind_pdc[2] | (kind_pdc[0] & pdch[1]);
    // counter and index go back down the pipe
    assign pdc_out.pdch  = pdch;
    assign pdc_out.index = index;

    assign try_to_pdc = (ex_info.kind_ex == direct_jump);
    // ignored while the table is still being swept
    assign upd_take = update_en & try_to_pdc & ready;

    // based on the counter seen at prediction, not the current entry
    always_comb begin
        cnt_new = ex_info.pdch_ex;
        if (ex_info.taken_real) begin
            if (ex_info.pdch_ex != pht_cnt_max) begin
                cnt_new = ex_info.pdch_ex + 1'b1;
            end
        end else begin
            if (ex_info.pdch_ex != pht_cnt_min) begin
                cnt_new = ex_info.pdch_ex - 1'b1;
            end
        end
    end

    assign pht_wr.wr_en    = upd_take;
    assign pht_wr.wr_index = ex_info.index_ex;
    assign pht_wr.wr_cnt   = cnt_new;

    // history follows the same accepted updates
    assign hist_shift = upd_take;
    assign hist_bit   = ex_info.taken_real;

endmodule

/* logic/branch_predictor_top.sv */
module branch_predictor_top import bp_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    // fetch
    input  pc_t       pc_reg,
    input  br_kind_t  kind_pdc,
    output pdc_info_s pdc_out,
    // execute
    input  logic      update_en,
    input  ex_info_s  ex_info,
    output logic      ready
);

    // fetch index from the hash
    bh_index_t index;
    // counter read at index
    pht_cnt_t  pdch;
    // execute side write, gated by ready
    pht_wr_s   pht_wr;
    // sweep write after reset
    pht_wr_s   init_wr;
    logic      hist_shift;
    logic      hist_bit;

    bh_hash u_bh_hash (
        .clk        (clk),
        .arst_n     (arst_n),
        .pc_reg     (pc_reg),
        .hist_shift (hist_shift),
        .hist_bit   (hist_bit),
        .index      (index)
    );

    bpht u_bpht (
        .clk     (clk),
        .index   (index),
        .pdch    (pdch),
        .pht_wr  (pht_wr),
        .init_wr (init_wr)
    );

    pht_init_fsm u_pht_init_fsm (
        .clk     (clk),
        .arst_n  (arst_n),
        .init_wr (init_wr),
        .ready   (ready)
    );

    aim_predictor0 u_aim_predictor0 (
        .ready      (ready),
        .update_en  (update_en),
        .ex_info    (ex_info),
        .kind_pdc   (kind_pdc),
        .pdch       (pdch),
        .index      (index),
        .pdc_out    (pdc_out),
        .pht_wr     (pht_wr),
        .hist_shift (hist_shift),
        .hist_bit   (hist_bit)
    );

endmodule

/* sim/branch_predictor_tb.sv */
module branch_predictor_tb import bp_pkg::*; ();

    logic      clk;
    logic      arst_n;
    pc_t       pc_reg;
    br_kind_t  kind_pdc;
    pdc_info_s pdc_out;
    logic      update_en;
    ex_info_s  ex_info;
    logic      ready;

    // reference model of the table and the global history
    pht_cnt_t    model_pht [pht_depth];
    bh_index_t   model_hist;
    logic [31:0] rng_state;
    int          error_count;
    int          check_count;
    // set once ready has been seen after reset
    logic        init_ok;

    br_kind_t kind_list [6] = '{not_jump, direct_jump, ret, indirect_jump, call, jump};

    branch_predictor_top u_branch_predictor_top (
        .clk       (clk),
        .arst_n    (arst_n),
        .pc_reg    (pc_reg),
        .kind_pdc  (kind_pdc),
        .pdc_out   (pdc_out),
        .update_en (update_en),
        .ex_info   (ex_info),
        .ready     (ready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic pc_t random_pc();
        logic [31:0] r;
        r = xorshift32();
        return r[addr_width-1:0];
    endfunction

    // random upper bits, low bits chosen so the fetch lands on idx
    function automatic pc_t pc_for_index(input bh_index_t idx);
        logic [31:0] r;
        r = xorshift32();
        return {r[addr_width-h_width-1:0], idx ^ model_hist};
    endfunction

    // one step of a 2-bit saturating counter
    function automatic pht_cnt_t step_cnt(input pht_cnt_t c, input logic taken);
        if (taken && c != 2'd3) begin
            return c + 2'd1;
        end else if (!taken && c != 2'd0) begin
            return c - 2'd1;
        end
        return c;
    endfunction

    function automatic ex_info_s make_ex(input bh_index_t idx, input pht_cnt_t cnt,
                                         input br_kind_t kind, input logic taken);
        ex_info_s ex;
        ex.pc_ex      = '0;
        ex.index_ex   = idx;
        ex.kind_ex    = kind;
        ex.taken_real = taken;
        ex.pdch_ex    = cnt;
        return ex;
    endfunction

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        assert (got === exp) else begin
            error_count++;
            $display("FAIL %0t %s expected %0h got %0h", $time, name, exp, got);
        end
    endtask

    task automatic report_and_finish();
        $display("checks: %0d errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    endtask

    // drive fetch and execute side, check pdc_out mid cycle, then advance the model
    task automatic drive_cycle(input pc_t pc, input br_kind_t kind, input logic upd,
                               input ex_info_s ex, output pdc_info_s seen);
        bh_index_t exp_idx;
        pht_cnt_t  exp_cnt;
        logic      exp_taken;
        @(posedge clk);
        pc_reg    <= pc;
        kind_pdc  <= kind;
        update_en <= upd;
        ex_info   <= ex;
        @(negedge clk);
        exp_idx   = pc[h_width-1:0] ^ model_hist;
        exp_cnt   = model_pht[exp_idx];
        exp_taken = kind[2] | (kind[0] & exp_cnt[1]);
        seen      = pdc_out;
        check_field("pdc_out.index", 32'(pdc_out.index), 32'(exp_idx));
        check_field("pdc_out.pdch", 32'(pdc_out.pdch), 32'(exp_cnt));
        check_field("pdc_out.taken_pdc", 32'(pdc_out.taken_pdc), 32'(exp_taken));
        // write and shift land on the next edge
        if (upd && ex.kind_ex == direct_jump) begin
            model_pht[ex.index_ex] = step_cnt(ex.pdch_ex, ex.taken_real);
            model_hist = {model_hist[h_width-2:0], ex.taken_real};
        end
    endtask

    task automatic wait_ready(output logic ok);
        int cycles;
        cycles = 0;
        while (ready !== 1'b1 && cycles < 400) begin
            @(negedge clk);
            cycles++;
        end
        ok = (ready === 1'b1);
        if (!ok) begin
            error_count++;
            $display("timeout, ready did not rise within 400 cycles of reset release");
        end
    endtask

    task automatic test_init(output logic ok);
        pdc_info_s seen;
        logic [4:0] n;
        @(negedge clk);
        check_field("ready", 32'(ready), 32'd0);
        // strobe during the sweep, must not shift history
        @(posedge clk);
        update_en <= 1'b1;
        ex_info   <= make_ex(8'h00, pht_init_val, direct_jump, 1'b1);
        @(posedge clk);
        update_en <= 1'b0;
        wait_ready(ok);
        if (ok) begin
            for (n = 5'd0; n < 5'd16; n++) begin
                drive_cycle(random_pc(), direct_jump, 1'b0,
                            make_ex('0, '0, not_jump, 1'b0), seen);
            end
        end
    endtask

    task automatic test_kind_decode();
        pc_t        pc;
        pdc_info_s  seen;
        bh_index_t  target;
        logic [2:0] k;
        logic [3:0] n;
        pc = 30'h0000_1234;
        for (k = 3'd0; k < 3'd6; k++) begin
            drive_cycle(pc, kind_list[k], 1'b0, make_ex('0, '0, not_jump, 1'b0), seen);
        end
        // train the entry this pc will map to once history settles
        for (n = 4'd0; n < 4'd10; n++) begin
            target = pc[h_width-1:0] ^ {model_hist[h_width-2:0], 1'b1};
            drive_cycle(pc, direct_jump, 1'b1,
                        make_ex(target, model_pht[target], direct_jump, 1'b1), seen);
        end
        for (k = 3'd0; k < 3'd6; k++) begin
            drive_cycle(pc, kind_list[k], 1'b0, make_ex('0, '0, not_jump, 1'b0), seen);
        end
        // entry read by the dut must now be strong taken
        check_field("trained counter", 32'(seen.pdch), 32'd3);
    endtask

    task automatic test_saturation();
        pht_cnt_t   exp_seq [10] = '{2'd1, 2'd2, 2'd3, 2'd3, 2'd3, 2'd2, 2'd1, 2'd0, 2'd0, 2'd0};
        pdc_info_s  seen;
        pdc_info_s  dummy;
        bh_index_t  idx;
        logic [3:0] step;
        logic [31:0] r;
        int         tries;
        r     = xorshift32();
        idx   = r[h_width-1:0];
        tries = 0;
        // find an untouched entry
        while (model_pht[idx] != pht_init_val && tries < 256) begin
            idx = idx + 8'd1;
            tries++;
        end
        for (step = 4'd0; step < 4'd10; step++) begin
            drive_cycle(pc_for_index(idx), direct_jump, 1'b0, make_ex('0, '0, not_jump, 1'b0), seen);
            check_field("saturating counter", 32'(seen.pdch), 32'(exp_seq[step]));
            if (step < 4'd9) begin
                // four taken updates, then not taken
                drive_cycle(pc_for_index(idx), direct_jump, 1'b1,
                            make_ex(idx, seen.pdch, direct_jump, step < 4'd4), dummy);
            end
        end
    endtask

    task automatic test_history();
        pdc_info_s   seen;
        bh_index_t   idx;
        logic [31:0] r;
        logic [3:0]  n;
        for (n = 4'd0; n < 4'd12; n++) begin
            r   = xorshift32();
            idx = r[h_width-1:0];
            drive_cycle(random_pc(), direct_jump, 1'b1,
                        make_ex(idx, model_pht[idx], direct_jump, r[8]), seen);
        end
        drive_cycle(random_pc(), direct_jump, 1'b0, make_ex('0, '0, not_jump, 1'b0), seen);
    endtask

    task automatic test_filter();
        pdc_info_s   seen;
        bh_index_t   idx;
        pht_cnt_t    cnt_before;
        logic [31:0] r;
        logic [2:0]  k;
        r          = xorshift32();
        idx        = r[h_width-1:0];
        cnt_before = model_pht[idx];
        // other kinds with the strobe, direct jump without it
        for (k = 3'd0; k < 3'd6; k++) begin
            drive_cycle(pc_for_index(idx), direct_jump, kind_list[k] != direct_jump,
                        make_ex(idx, model_pht[idx], kind_list[k], k[0]), seen);
        end
        drive_cycle(pc_for_index(idx), direct_jump, 1'b0, make_ex('0, '0, not_jump, 1'b0), seen);
        check_field("filtered counter", 32'(seen.pdch), 32'(cnt_before));
        // pc was folded with the old history, so a shift moves the index
        check_field("filtered index", 32'(seen.index), 32'(idx));
    endtask

    task automatic test_random_mix();
        pdc_info_s   pending [$];
        pdc_info_s   seen;
        pdc_info_s   old;
        ex_info_s    ex;
        logic [31:0] r;
        logic        upd;
        int          n;
        for (n = 0; n < 200; n++) begin
            r   = xorshift32();
            upd = r[0] && (pending.size() > 0);
            ex  = make_ex('0, '0, not_jump, 1'b0);
            if (upd) begin
                // stale counter from an earlier fetch
                old = pending.pop_front();
                ex  = make_ex(old.index, old.pdch, direct_jump, r[1]);
            end
            drive_cycle(random_pc(), kind_list[3'(r[15:8] % 6)], upd, ex, seen);
            if (r[2]) begin
                pending.push_back(seen);
            end
        end
    endtask

    initial begin
        rng_state   = 32'h1a46_4c90;
        error_count = 0;
        check_count = 0;
        init_ok     = 1'b0;
        arst_n      = 1'b0;
        pc_reg      = '0;
        kind_pdc    = not_jump;
        update_en   = 1'b0;
        ex_info     = '0;
        model_pht   = '{default: pht_init_val};
        model_hist  = '0;
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;
        test_init(init_ok);
        // no point training a table that never came out of its sweep
        if (init_ok) begin
            test_kind_decode();
            test_saturation();
            test_history();
            test_filter();
            test_random_mix();
        end
        report_and_finish();
    end

endmodule

/* branch_predictor_top.f */
logic/bp_pkg.sv
logic/bh_hash.sv
logic/bpht.sv
logic/pht_init_fsm.sv
logic/aim_predictor0.sv
logic/branch_predictor_top.sv
sim/branch_predictor_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the branch predictor testbench with verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module branch_predictor_tb \
    -f branch_predictor_top.f -Mdir obj_dir || exit 1
out="$(./obj_dir/Vbranch_predictor_tb)"
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qF '*** PASSED ***' && exit 0 || exit 1
